/* logic/ksClockEnable.sv */
////////////////////////////////////////////////////////////////////////////
// Clock-enable timer.
// clken is a registered one-clock pulse every CLKEN_DIV clocks.
// It is low out of reset; the first pulse comes CLKEN_DIV clocks
// after reset is released. Needs CLKEN_DIV of 2 or more.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksClockEnable
(
   input  logic clk,
   input  logic rst,
   output logic clken
);

   // Down-counter, wraps at zero
   logic [ksConsPkg::CLKEN_W-1:0] divCount;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         divCount <= ksConsPkg::CLKEN_W'(ksConsPkg::CLKEN_DIV - 1);
         clken    <= 1'b0;
      end
      else
      begin
         // Pulse on the wrap, reload the period
         clken <= (divCount == '0);
         if (divCount == '0)
            divCount <= ksConsPkg::CLKEN_W'(ksConsPkg::CLKEN_DIV - 1);
         else
            divCount <= divCount - 1'b1;
      end
   end

   // Ticks are isolated single-clock pulses
   assert property (@(posedge clk) disable iff (rst) clken |=> !clken);

endmodule

/* logic/ksConsPkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the console control corner.
// The microword is a toy layout for a six-word microprogram, not a
// real instruction set. The special field is read either as console
// set/clear bits or as a jump address, depending on specSel.
// skipSel has a fourth code, EXEC, so the microprogram can split the
// single-step path away from the run loop.
////////////////////////////////////////////////////////////////////////////

package ksConsPkg;

   // Clocks per clock-enable tick
   localparam int CLKEN_DIV = 4;
   // Width of the tick down-counter
   localparam int CLKEN_W   = $clog2(CLKEN_DIV);
   // Micro-PC width and microprogram length
   localparam int UADDR_W   = 3;
   localparam int ROM_DEPTH = 6;
   // Instruction counter width
   localparam int COUNT_W   = 16;
   // Width of the special field
   localparam int SPEC_W    = 6;

   // Special-function selector
   typedef enum logic [1:0]
   {
      NONE = 2'd0,
      CONS = 2'd1,
      JUMP = 2'd2
   } specSel_e;

   // Skip condition, tested against console status
   typedef enum logic [1:0]
   {
      NEVER        = 2'd0,
      CONT_OR_EXEC = 2'd1,
      HALTREQ      = 2'd2,
      EXEC         = 2'd3
   } skipSel_e;

   // Console special function, one bit per action
   typedef struct packed
   {
      logic setHalt;
      logic clrHalt;
      logic clrRun;
      logic clrCont;
      logic clrExec;
      logic clrHaltReq;
   } consBits_t;

   // Jump form of the special field, address in the low bits
   typedef struct packed
   {
      logic [SPEC_W-UADDR_W-1:0] pad;
      logic [UADDR_W-1:0]        addr;
   } jumpBits_t;

   // Same six bits, two meanings
   typedef union packed
   {
      consBits_t cons;
      jumpBits_t jump;
   } specField_u;

   // Microword, 17 bits
   typedef struct packed
   {
      specSel_e           specSel;
      skipSel_e           skipSel;
      logic               countInstr;
      logic [UADDR_W-1:0] nextAddr;
      logic [UADDR_W-1:0] skipAddr;
      specField_u         spec;
   } uWord_t;

   // Console command, travels with cmdValid
   typedef struct packed
   {
      logic run;
      logic cont;
      logic exec;
      logic halt;
   } consCmd_t;

   // Console status flags
   typedef struct packed
   {
      logic run;
      logic cont;
      logic exec;
      logic halt;
      logic haltReq;
   } consStatus_t;

endpackage

/* logic/ksConsoleIntf.sv */
////////////////////////////////////////////////////////////////////////////
// Console interface status flags.
// Commands are taken when cmdValid is high on a tick, since cmdReady
// is clken. A command set wins over a microcode clear in the same
// tick. HALT itself is only set and cleared by microcode; the halt
// command raises haltReq instead.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksConsoleIntf
(
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    clken,
   input  ksConsPkg::consCmd_t     cmd,
   input  logic                    cmdValid,
   input  ksConsPkg::specField_u   spec,
   input  logic                    consStrobe,
   output logic                    cmdReady,
   output ksConsPkg::consStatus_t  status
);

   logic                 cmdTake;
   ksConsPkg::consCmd_t  setCmd;
   ksConsPkg::consBits_t consOp;

   // Back-pressure until the next tick
   assign cmdReady = clken;
   assign cmdTake  = cmdValid && clken;

   // Qualified command bits and microcode actions
   assign setCmd = cmdTake ? cmd : '0;
   assign consOp = consStrobe ? spec.cons : '0;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         status <= '0;
      else
      begin
         // RUN
         if (setCmd.run)
            status.run <= 1'b1;
         else if (consOp.clrRun)
            status.run <= 1'b0;

         // CONTINUE
         if (setCmd.cont)
            status.cont <= 1'b1;
         else if (consOp.clrCont)
            status.cont <= 1'b0;

         // EXECUTE
         if (setCmd.exec)
            status.exec <= 1'b1;
         else if (consOp.clrExec)
            status.exec <= 1'b0;

         // HALT, microcode only
         if (consOp.setHalt)
            status.halt <= 1'b1;
         else if (consOp.clrHalt)
            status.halt <= 1'b0;

         // Halt request from the halt switch
         if (setCmd.halt)
            status.haltReq <= 1'b1;
         else if (consOp.clrHaltReq)
            status.haltReq <= 1'b0;
      end
   end

endmodule

/* logic/ksConsoleTop.sv */
////////////////////////////////////////////////////////////////////////////
// Console control top level.
// Timer, control ROM, microsequencer and console interface.
// cmd is accepted on a clock where cmdValid and cmdReady are high;
// cmdReady only rises on clock-enable ticks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksConsoleTop
(
   input  logic                           clk,
   input  logic                           rst,
   input  ksConsPkg::consCmd_t            cmd,
   input  logic                           cmdValid,
   output logic                           cmdReady,
   output ksConsPkg::consStatus_t         status,
   output logic [ksConsPkg::COUNT_W-1:0]  instrCount
);

   // Tick and microcode paths
   logic                          clken;
   logic [ksConsPkg::UADDR_W-1:0] addr;
   ksConsPkg::uWord_t             word;
   ksConsPkg::specField_u         spec;
   logic                          consStrobe;

   ksClockEnable ksClockEnable_i
   (
      .clk   (clk),
      .rst   (rst),
      .clken (clken)
   );

   ksControlRom ksControlRom_i
   (
      .clk  (clk),
      .rst  (rst),
      .addr (addr),
      .word (word)
   );

   // Status feeds back into the skip logic
   ksMicroSequencer ksMicroSequencer_i
   (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .word       (word),
      .status     (status),
      .addr       (addr),
      .spec       (spec),
      .consStrobe (consStrobe),
      .instrCount (instrCount)
   );

   ksConsoleIntf ksConsoleIntf_i
   (
      .clk        (clk),
      .rst        (rst),
      .clken      (clken),
      .cmd        (cmd),
      .cmdValid   (cmdValid),
      .spec       (spec),
      .consStrobe (consStrobe),
      .cmdReady   (cmdReady),
      .status     (status)
   );

endmodule

/* logic/ksControlRom.sv */
////////////////////////////////////////////////////////////////////////////
// Control ROM for the six-word console microprogram.
// Read is registered on every clock, so the word for a new micro-PC
// is ready one clock later, well before the next tick.
// Addresses 6 and 7 read back word 0.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksControlRom
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic [ksConsPkg::UADDR_W-1:0]  addr,
   output ksConsPkg::uWord_t              word
);

   // Decoded table entry for addr
   ksConsPkg::uWord_t romData;

   always_comb
   begin
      romData = '0;
      case (addr)
         3'd1:
         begin
            // Wait for CONT or EXEC, spin here otherwise
            romData.specSel       = ksConsPkg::JUMP;
            romData.skipSel       = ksConsPkg::CONT_OR_EXEC;
            romData.skipAddr      = 3'd2;
            romData.spec.jump.addr = 3'd1;
         end
         3'd2:
         begin
            // Leave halt; EXEC goes to single step
            romData.specSel           = ksConsPkg::CONS;
            romData.spec.cons.clrCont = 1'b1;
            romData.spec.cons.clrHalt = 1'b1;
            romData.skipSel           = ksConsPkg::EXEC;
            romData.skipAddr          = 3'd4;
            romData.nextAddr          = 3'd3;
         end
         3'd3:
         begin
            // Run loop, one instruction per tick
            romData.specSel        = ksConsPkg::JUMP;
            romData.spec.jump.addr = 3'd3;
            romData.countInstr     = 1'b1;
            romData.skipSel        = ksConsPkg::HALTREQ;
            romData.skipAddr       = 3'd5;
         end
         3'd4:
         begin
            // Single step then back to halt
            romData.specSel           = ksConsPkg::CONS;
            romData.spec.cons.clrExec = 1'b1;
            romData.countInstr        = 1'b1;
            romData.nextAddr          = 3'd0;
         end
         3'd5:
         begin
            // Halt request seen, drop RUN
            romData.specSel              = ksConsPkg::CONS;
            romData.spec.cons.clrRun     = 1'b1;
            romData.spec.cons.clrHaltReq = 1'b1;
            romData.nextAddr             = 3'd0;
         end
         default:
         begin
            // Word 0, enter halt
            romData.specSel           = ksConsPkg::CONS;
            romData.spec.cons.setHalt = 1'b1;
            romData.nextAddr          = 3'd1;
         end
      endcase
   end

   // Output register; all-zero word is a harmless NOP
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         word <= '0;
      else
         word <= romData;
   end

   // Halt set and clear never share a console word
   assert property (@(posedge clk) disable iff (rst)
      (word.specSel == ksConsPkg::CONS) |->
         !(word.spec.cons.setHalt && word.spec.cons.clrHalt));

endmodule

/* logic/ksMicroSequencer.sv */
////////////////////////////////////////////////////////////////////////////
// Microsequencer.
// Executes the current ROM word on each clken tick once out of the
// RESET state. Skip beats jump, jump beats nextAddr.
// consStrobe and spec are combinational and only mean something
// while consStrobe is high.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksMicroSequencer
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           clken,
   input  ksConsPkg::uWord_t              word,
   input  ksConsPkg::consStatus_t         status,
   output logic [ksConsPkg::UADDR_W-1:0]  addr,
   output ksConsPkg::specField_u          spec,
   output logic                           consStrobe,
   output logic [ksConsPkg::COUNT_W-1:0]  instrCount
);

   typedef enum logic
   {
      stReset   = 1'b0,
      stRunning = 1'b1
   } state_t;

   state_t                        state;
   logic                          execTick;
   logic                          skipTaken;
   logic [ksConsPkg::UADDR_W-1:0] nextPc;

   // A tick that actually runs a microword
   assign execTick = clken && (state == stRunning);

   //////////////////////////////////////////////////////////////////////////
   // Skip and next address
   //////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      skipTaken = 1'b0;
      case (word.skipSel)
         ksConsPkg::NEVER:        skipTaken = 1'b0;
         ksConsPkg::CONT_OR_EXEC: skipTaken = status.cont || status.exec;
         ksConsPkg::HALTREQ:      skipTaken = status.haltReq;
         ksConsPkg::EXEC:         skipTaken = status.exec;
      endcase

      // Jump field only valid when specSel says so
      if (skipTaken)
         nextPc = word.skipAddr;
      else if (word.specSel == ksConsPkg::JUMP)
         nextPc = word.spec.jump.addr;
      else
         nextPc = word.nextAddr;
   end

   // Console special function goes straight out
   assign spec       = word.spec;
   assign consStrobe = execTick && (word.specSel == ksConsPkg::CONS);

   //////////////////////////////////////////////////////////////////////////
   // State, micro-PC and instruction counter
   //////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state      <= stReset;
         addr       <= '0;
         instrCount <= '0;
      end
      else if (clken)
      begin
         case (state)
            stReset:
            begin
               // First tick only arms the machine
               state <= stRunning;
            end
            default:
            begin
               addr <= nextPc;
               if (word.countInstr)
                  instrCount <= instrCount + ksConsPkg::COUNT_W'(1);
            end
         endcase
      end
   end

   // Micro-PC never leaves the programmed words
   assert property (@(posedge clk) disable iff (rst) addr < ksConsPkg::ROM_DEPTH);

endmodule

/* run.sh */
#!/bin/sh
# Build and run the console testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module ksConsoleTb -Mdir obj_dir
./obj_dir/VksConsoleTb | tee sim.log
if grep -q "All checks passed" sim.log; then
   echo "Simulation PASSED"
else
   echo "Simulation FAILED"
   exit 1
fi

/* tb.f */
logic/ksConsPkg.sv
logic/ksClockEnable.sv
logic/ksControlRom.sv
logic/ksMicroSequencer.sv
logic/ksConsoleIntf.sv
logic/ksConsoleTop.sv
tb/ksConsoleTb.sv

/* tb/ksConsoleTb.sv */
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the console control top level.
// Inputs change on the falling edge and outputs are sampled there too.
// The tests share DUT state and must run in the order given below.
// The first error stops the run.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ksConsoleTb;

   logic                          clk;
   logic                          rst;
   ksConsPkg::consCmd_t           cmd;
   logic                          cmdValid;
   logic                          cmdReady;
   ksConsPkg::consStatus_t        status;
   logic [ksConsPkg::COUNT_W-1:0] instrCount;

   // Generous bound for any flag to settle
   int waitLimit = 4 * ksConsPkg::CLKEN_DIV;

   ksConsoleTop ksConsoleTop_i
   (
      .clk        (clk),
      .rst        (rst),
      .cmd        (cmd),
      .cmdValid   (cmdValid),
      .cmdReady   (cmdReady),
      .status     (status),
      .instrCount (instrCount)
   );

   // 20 ns clock
   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic checkEq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (actual !== expected)
         failRun($sformatf("** Error: %s expected 0x%0h, actual 0x%0h",
                           name, expected, actual));
   endtask

   // Status bit by name
   function automatic logic statusBit(input string name);
      case (name)
         "run":     return status.run;
         "cont":    return status.cont;
         "exec":    return status.exec;
         "halt":    return status.halt;
         "haltReq": return status.haltReq;
         default:   return 1'bx;
      endcase
   endfunction

   task automatic waitStatus(input string name, input logic value, input int limit);
      int waitCount;
      waitCount = 0;
      while (statusBit(name) !== value && waitCount < limit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (statusBit(name) !== value)
         failRun($sformatf("Timed out waiting for status.%s to become %0d", name, value));
   endtask

   task automatic waitCountChange(input logic [ksConsPkg::COUNT_W-1:0] from,
                                  input int limit);
      int waitCount;
      waitCount = 0;
      while (instrCount == from && waitCount < limit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (instrCount == from)
         failRun("Timed out waiting for the instruction counter to move");
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic sendCmd(input ksConsPkg::consCmd_t c);
      int waitCount;
      waitCount = 0;
      cmd      = c;
      cmdValid = 1'b1;
      while (!cmdReady && waitCount < waitLimit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (!cmdReady)
         failRun("Timed out waiting for cmdReady");
      // Rising edge in between takes the command
      @(negedge clk);
      cmdValid = 1'b0;
      cmd      = '0;
   endtask

   // Halted and idle for a number of clocks
   task automatic holdSteady(input int clocks, input logic [ksConsPkg::COUNT_W-1:0] count);
      repeat (clocks)
      begin
         @(negedge clk);
         checkEq("instrCount", 32'(count), 32'(instrCount));
         checkEq("status.halt", 32'd1, 32'(status.halt));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic checkReset();
      checkEq("status", 32'd0, 32'(status));
      checkEq("instrCount", 32'd0, 32'(instrCount));
      checkEq("cmdReady", 32'd0, 32'(cmdReady));
      // Word 0 raises HALT on the first executed tick
      waitStatus("halt", 1'b1, waitLimit);
      checkEq("status.run", 32'd0, 32'(status.run));
      checkEq("status.cont", 32'd0, 32'(status.cont));
      checkEq("status.exec", 32'd0, 32'(status.exec));
      checkEq("status.haltReq", 32'd0, 32'(status.haltReq));
   endtask

   task automatic checkRunWhileHalted();
      ksConsPkg::consCmd_t c;
      c = '0;
      c.run = 1'b1;
      sendCmd(c);
      checkEq("status.run", 32'd1, 32'(status.run));
      checkEq("status.halt", 32'd1, 32'(status.halt));
      // Halt loop ignores RUN
      holdSteady(waitLimit, '0);
      checkEq("status.run", 32'd1, 32'(status.run));
   endtask

   task automatic checkContAndHalt();
      ksConsPkg::consCmd_t           c;
      logic [ksConsPkg::COUNT_W-1:0] stopCount;
      c = '0;
      c.cont = 1'b1;
      sendCmd(c);
      checkEq("status.cont", 32'd1, 32'(status.cont));
      waitStatus("halt", 1'b0, waitLimit);
      checkEq("status.cont", 32'd0, 32'(status.cont));
      waitCountChange('0, waitLimit);
      // Ask the run loop to stop
      c = '0;
      c.halt = 1'b1;
      sendCmd(c);
      checkEq("status.haltReq", 32'd1, 32'(status.haltReq));
      waitStatus("haltReq", 1'b0, waitLimit);
      checkEq("status.run", 32'd0, 32'(status.run));
      waitStatus("halt", 1'b1, waitLimit);
      stopCount = instrCount;
      holdSteady(waitLimit, stopCount);
   endtask

   task automatic checkBackPressure();
      int lowCount;
      int waitCount;
      waitCount = 0;
      // Start between ticks
      while (cmdReady && waitCount < waitLimit)
      begin
         @(negedge clk);
         waitCount++;
      end
      if (cmdReady)
         failRun("Timed out waiting for cmdReady to drop");
      cmd       = '0;
      cmd.run   = 1'b1;
      cmdValid  = 1'b1;
      waitCount = 0;
      // No acceptance while cmdReady is low
      while (!cmdReady && waitCount < waitLimit)
      begin
         checkEq("status.run", 32'd0, 32'(status.run));
         @(negedge clk);
         waitCount++;
      end
      if (!cmdReady)
         failRun("Timed out waiting for cmdReady with cmdValid held");
      @(negedge clk);
      checkEq("status.run", 32'd1, 32'(status.run));
      lowCount = 0;
      while (!cmdReady && lowCount < waitLimit)
      begin
         @(negedge clk);
         lowCount++;
      end
      checkEq("cmdReady low clocks", 32'(ksConsPkg::CLKEN_DIV - 1), 32'(lowCount));
      cmdValid = 1'b0;
      cmd      = '0;
   endtask

   task automatic checkSingleStep();
      ksConsPkg::consCmd_t           c;
      logic [ksConsPkg::COUNT_W-1:0] startCount;
      startCount = instrCount;
      c = '0;
      c.exec = 1'b1;
      sendCmd(c);
      checkEq("status.exec", 32'd1, 32'(status.exec));
      waitStatus("exec", 1'b0, waitLimit);
      waitStatus("halt", 1'b1, waitLimit);
      // Exactly one instruction for one step
      checkEq("instrCount", 32'(startCount + 1'b1), 32'(instrCount));
      holdSteady(waitLimit, startCount + 1'b1);
   endtask

   initial
   begin
      clk      = 1'b0;
      rst      = 1'b1;
      cmd      = '0;
      cmdValid = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      checkReset();
      checkRunWhileHalted();
      checkContAndHalt();
      checkBackPressure();
      checkSingleStep();
      $display("All checks passed");
      $finish;
   end

endmodule
